// File: include/rsa_params.svh
`ifndef RSA_PARAMS_SVH
`define RSA_PARAMS_SVH

// operand and counter sizes
`define RSA_W      256
`define RSA_CNT_W  8

// bus geometry
`define RSA_BUS_W  32
`define RSA_WORDS  8
`define RSA_ADR_W  6

// word addresses, each operand block starts on a multiple of 8
`define RSA_A_MSG  6'd0
`define RSA_A_KEY  6'd8
`define RSA_A_N    6'd16
`define RSA_A_CTRL 6'd24
`define RSA_A_STAT 6'd25
`define RSA_A_ANS  6'd32

`endif

// File: src/rsa_pkg.sv
`default_nettype none

`include "rsa_params.svh"

package rsa_pkg;

	// one full-width operand
	typedef logic [`RSA_W-1:0] rsa_word_t;

	// operands latched by the core at start
	typedef struct packed {
		rsa_word_t msg;
		rsa_word_t key;
		rsa_word_t n;
	} rsa_job_t;

	typedef struct packed {
		rsa_word_t ans;
	} rsa_result_t;

	// wishbone classic master to slave
	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic                   we;
		logic [`RSA_ADR_W-1:0]  adr;
		logic [`RSA_BUS_W-1:0]  dat;
		logic [`RSA_BUS_W/8-1:0] sel;
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic                  ack;
		logic [`RSA_BUS_W-1:0] dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

// File: src/rsa_prep.sv
`timescale 1ns/100ps
`default_nettype none

`include "rsa_params.svh"

module rsa_prep
	import rsa_pkg::*;
(
	input  wire       i_clk,
	input  wire       i_rst,
	input  wire       i_start,
	input  wire       rsa_word_t i_a,
	input  wire       rsa_word_t i_n,
	output logic      o_done,
	output rsa_word_t o_t
);

	localparam int W = `RSA_W;
	localparam logic [`RSA_CNT_W-1:0] LAST_BIT = `RSA_CNT_W'(W - 1);

	logic [W-1:0]          t_r;
	// guard bit holds the carry of the doubling
	logic [W:0]            t_dbl;
	logic [W-1:0]          t_nxt;
	logic [`RSA_CNT_W-1:0] cnt_r;
	logic                  run_r;
	logic                  fin_r;

	// double, then pull back below n
	always_comb begin
		t_dbl = {t_r, 1'b0};
		if (t_dbl >= {1'b0, i_n}) begin
			t_nxt = t_dbl[W-1:0] - i_n;
		end else begin
			t_nxt = t_dbl[W-1:0];
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			run_r  <= 1'b0;
			fin_r  <= 1'b0;
			cnt_r  <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= fin_r;
			fin_r  <= 1'b0;
			if (i_start) begin
				run_r <= 1'b1;
				cnt_r <= '0;
			end else if (run_r) begin
				cnt_r <= cnt_r + 1'b1;
				// 256th doubling hands over to the output cycle
				if (cnt_r == LAST_BIT) begin
					run_r <= 1'b0;
					fin_r <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_start) begin
			t_r <= i_a;
		end else if (run_r) begin
			t_r <= t_nxt;
		end
		if (fin_r) begin
			o_t <= t_r;
		end
	end

endmodule

`default_nettype wire

// File: src/rsa_mont.sv
`timescale 1ns/100ps
`default_nettype none

`include "rsa_params.svh"

module rsa_mont
	import rsa_pkg::*;
(
	input  wire       i_clk,
	input  wire       i_rst,
	input  wire       i_start,
	input  wire       rsa_word_t i_a,
	input  wire       rsa_word_t i_b,
	input  wire       rsa_word_t i_n,
	output logic      o_done,
	output rsa_word_t o_m
);

	localparam int W = `RSA_W;
	localparam logic [`RSA_CNT_W-1:0] LAST_BIT = `RSA_CNT_W'(W - 1);

	// two guard bits, the running sum stays below 4n
	logic [W+1:0]          m_r;
	logic [W+1:0]          sum;
	logic [W+1:0]          m_nxt;
	logic [W+1:0]          m_red;
	logic [`RSA_CNT_W-1:0] cnt_r;
	logic                  run_r;
	logic                  fin_r;

	always_comb begin
		sum = m_r;
		if (i_a[cnt_r]) begin
			sum = sum + {2'b00, i_b};
		end
		// make it even so the halving is exact mod n
		if (sum[0]) begin
			sum = sum + {2'b00, i_n};
		end
		m_nxt = sum >> 1;
	end

	// after the last iteration m is below 2n
	always_comb begin
		if (m_r >= {2'b00, i_n}) begin
			m_red = m_r - {2'b00, i_n};
		end else begin
			m_red = m_r;
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			run_r  <= 1'b0;
			fin_r  <= 1'b0;
			cnt_r  <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= fin_r;
			fin_r  <= 1'b0;
			if (i_start) begin
				run_r <= 1'b1;
				cnt_r <= '0;
			end else if (run_r) begin
				cnt_r <= cnt_r + 1'b1;
				if (cnt_r == LAST_BIT) begin
					run_r <= 1'b0;
					fin_r <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_start) begin
			m_r <= '0;
		end else if (run_r) begin
			m_r <= m_nxt;
		end
		// reduction cycle
		if (fin_r) begin
			o_m <= m_red[W-1:0];
		end
	end

endmodule

`default_nettype wire

// File: src/rsa_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "rsa_params.svh"

module rsa_core
	import rsa_pkg::*;
(
	input  wire         i_clk,
	input  wire         i_rst,
	input  wire         i_start,
	input  wire         rsa_job_t i_job,
	output logic        o_busy,
	output logic        o_done,
	output rsa_result_t o_result
);

	localparam logic [`RSA_CNT_W-1:0] LAST_BIT = `RSA_CNT_W'(`RSA_W - 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_PREP,
		S_MONT,
		S_CALC
	} state_t;

	state_t                state_r;
	logic [`RSA_CNT_W-1:0] cnt_r;
	logic                  prep_go_r;
	logic                  mont_go_r;
	logic                  prep_done;
	logic                  mul_done;
	logic                  sqr_done;
	rsa_word_t             prep_t;
	rsa_word_t             mul_m;
	rsa_word_t             sqr_m;
	rsa_job_t              job_r;
	rsa_word_t             prod_r;
	rsa_word_t             base_r;
	rsa_word_t             result_r;

	// base in montgomery form, product stays in normal form
	rsa_prep u_prep (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (prep_go_r),
		.i_a     (job_r.msg),
		.i_n     (job_r.n),
		.o_done  (prep_done),
		.o_t     (prep_t)
	);

	rsa_mont u_mont_mul (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (mont_go_r),
		.i_a     (prod_r),
		.i_b     (base_r),
		.i_n     (job_r.n),
		.o_done  (mul_done),
		.o_m     (mul_m)
	);

	rsa_mont u_mont_sqr (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (mont_go_r),
		.i_a     (base_r),
		.i_b     (base_r),
		.i_n     (job_r.n),
		.o_done  (sqr_done),
		.o_m     (sqr_m)
	);

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state_r   <= S_IDLE;
			cnt_r     <= '0;
			prep_go_r <= 1'b0;
			mont_go_r <= 1'b0;
			o_done    <= 1'b0;
		end else begin
			prep_go_r <= 1'b0;
			mont_go_r <= 1'b0;
			o_done    <= 1'b0;
			case (state_r)
				S_IDLE: begin
					if (i_start) begin
						state_r   <= S_PREP;
						prep_go_r <= 1'b1;
					end
				end
				S_PREP: begin
					if (prep_done) begin
						state_r   <= S_MONT;
						mont_go_r <= 1'b1;
						cnt_r     <= '0;
					end
				end
				S_MONT: begin
					// both units share the same latency
					if (mul_done && sqr_done) begin
						state_r <= S_CALC;
					end
				end
				S_CALC: begin
					if (cnt_r == LAST_BIT) begin
						state_r <= S_IDLE;
						o_done  <= 1'b1;
					end else begin
						state_r   <= S_MONT;
						mont_go_r <= 1'b1;
						cnt_r     <= cnt_r + 1'b1;
					end
				end
				default: begin
					state_r <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state_r == S_IDLE && i_start) begin
			job_r <= i_job;
		end
		if (state_r == S_PREP && prep_done) begin
			prod_r <= rsa_word_t'(1);
			base_r <= prep_t;
		end
		if (state_r == S_CALC) begin
			if (job_r.key[cnt_r]) begin
				prod_r <= mul_m;
			end
			base_r <= sqr_m;
			if (cnt_r == LAST_BIT) begin
				result_r <= job_r.key[cnt_r] ? mul_m : prod_r;
			end
		end
	end

	assign o_busy       = (state_r != S_IDLE);
	assign o_result.ans = result_r;

endmodule

`default_nettype wire

// File: src/rsa_wb_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "rsa_params.svh"

module rsa_wb_regs
	import rsa_pkg::*;
(
	input  wire      i_clk,
	input  wire      i_rst,
	input  wire      wb_req_t i_wb,
	output wb_rsp_t  o_wb,
	output rsa_job_t o_job,
	output logic     o_start,
	input  wire      i_busy,
	input  wire      i_done,
	input  wire      rsa_result_t i_result
);

	localparam int BW    = `RSA_BUS_W;
	localparam int AW    = `RSA_ADR_W;
	localparam int IDX_W = $clog2(`RSA_WORDS);

	localparam logic [AW-1:0] A_MSG  = `RSA_A_MSG;
	localparam logic [AW-1:0] A_KEY  = `RSA_A_KEY;
	localparam logic [AW-1:0] A_N    = `RSA_A_N;
	localparam logic [AW-1:0] A_CTRL = `RSA_A_CTRL;
	localparam logic [AW-1:0] A_STAT = `RSA_A_STAT;
	localparam logic [AW-1:0] A_ANS  = `RSA_A_ANS;

	logic [`RSA_WORDS-1:0][BW-1:0] msg_r;
	logic [`RSA_WORDS-1:0][BW-1:0] key_r;
	logic [`RSA_WORDS-1:0][BW-1:0] n_r;
	logic [`RSA_WORDS-1:0][BW-1:0] ans_r;
	logic                          req;
	logic                          req_new;
	logic                          wr_en;
	logic [IDX_W-1:0]              idx;
	logic [AW-IDX_W-1:0]           grp;
	logic                          ack_r;
	logic                          done_r;
	logic [BW-1:0]                 rd_nxt;
	logic [BW-1:0]                 rd_r;

	// byte-lane merge for partial writes
	function automatic logic [BW-1:0] merge_bytes(
		input logic [BW-1:0]   old_val,
		input logic [BW-1:0]   new_val,
		input logic [BW/8-1:0] sel
	);
		logic [BW-1:0] res;
		res = old_val;
		for (int i = 0; i < BW / 8; i++) begin
			if (sel[i]) begin
				res[i*8 +: 8] = new_val[i*8 +: 8];
			end
		end
		return res;
	endfunction

	assign req     = i_wb.cyc & i_wb.stb;
	assign req_new = req & ~ack_r;
	// data is taken on the ack cycle while the master still holds it
	assign wr_en   = req & ack_r & i_wb.we;
	assign idx     = i_wb.adr[IDX_W-1:0];
	assign grp     = i_wb.adr[AW-1:IDX_W];

	always_comb begin
		rd_nxt = '0;
		if (grp == A_MSG[AW-1:IDX_W]) begin
			rd_nxt = msg_r[idx];
		end else if (grp == A_KEY[AW-1:IDX_W]) begin
			rd_nxt = key_r[idx];
		end else if (grp == A_N[AW-1:IDX_W]) begin
			rd_nxt = n_r[idx];
		end else if (grp == A_ANS[AW-1:IDX_W]) begin
			rd_nxt = ans_r[idx];
		end else if (i_wb.adr == A_STAT) begin
			// busy covers the done pulse so both status bits move on the same cycle
			rd_nxt = {{(BW-2){1'b0}}, done_r, i_busy | i_done};
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			ack_r   <= 1'b0;
			o_start <= 1'b0;
			done_r  <= 1'b0;
			ans_r   <= '0;
		end else begin
			ack_r   <= req_new;
			// lines up with the ack of the control write
			o_start <= req_new & i_wb.we & (i_wb.adr == A_CTRL) &
				i_wb.sel[0] & i_wb.dat[0] & ~i_busy;
			if (o_start) begin
				done_r <= 1'b0;
			end else if (i_done) begin
				done_r <= 1'b1;
			end
			if (i_done) begin
				ans_r <= i_result.ans;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (req_new) begin
			rd_r <= rd_nxt;
		end
		if (wr_en) begin
			if (grp == A_MSG[AW-1:IDX_W]) begin
				msg_r[idx] <= merge_bytes(msg_r[idx], i_wb.dat, i_wb.sel);
			end
			if (grp == A_KEY[AW-1:IDX_W]) begin
				key_r[idx] <= merge_bytes(key_r[idx], i_wb.dat, i_wb.sel);
			end
			if (grp == A_N[AW-1:IDX_W]) begin
				n_r[idx] <= merge_bytes(n_r[idx], i_wb.dat, i_wb.sel);
			end
		end
	end

	assign o_wb.ack  = ack_r;
	assign o_wb.dat  = rd_r;
	assign o_job.msg = msg_r;
	assign o_job.key = key_r;
	assign o_job.n   = n_r;

endmodule

`default_nettype wire

// File: src/rsa_top.sv
`timescale 1ns/100ps
`default_nettype none

module rsa_top
	import rsa_pkg::*;
(
	input  wire     i_clk,
	input  wire     i_rst,
	input  wire     wb_req_t i_wb,
	output wb_rsp_t o_wb
);

	rsa_job_t    job;
	rsa_result_t result;
	logic        start;
	logic        busy;
	logic        done;

	// host side registers
	rsa_wb_regs u_wb_regs (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_wb     (i_wb),
		.o_wb     (o_wb),
		.o_job    (job),
		.o_start  (start),
		.i_busy   (busy),
		.i_done   (done),
		.i_result (result)
	);

	rsa_core u_core (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (start),
		.i_job    (job),
		.o_busy   (busy),
		.o_done   (done),
		.o_result (result)
	);

endmodule

`default_nettype wire

// File: dv/rsa_scoreboard.sv
`timescale 1ns/100ps
`default_nettype none

`include "rsa_params.svh"

module rsa_scoreboard
	import rsa_pkg::*;
(
	input  wire         i_clk,
	input  wire         i_rst,
	input  wire         wb_req_t i_req,
	input  wire         wb_rsp_t i_rsp,
	output int unsigned o_errors,
	output int unsigned o_checks
);

	localparam int BW = `RSA_BUS_W;
	// the prep pass alone outlasts this many cycles
	localparam int MIN_JOB = 256;

	rsa_word_t   msg_m;
	rsa_word_t   key_m;
	rsa_word_t   n_m;
	rsa_word_t   ans_m;
	rsa_word_t   ans_next;
	logic        pending;
	logic        done_m;
	int unsigned since_start;

	// plain square-and-multiply on double-width values
	function automatic rsa_word_t mod_pow(input rsa_word_t y, input rsa_word_t d,
			input rsa_word_t n);
		logic [2*`RSA_W-1:0] r;
		logic [2*`RSA_W-1:0] b;
		logic [2*`RSA_W-1:0] n_w;
		n_w = {{`RSA_W{1'b0}}, n};
		r = 1;
		b = {{`RSA_W{1'b0}}, y} % n_w;
		for (int i = 0; i < `RSA_W; i++) begin
			if (d[i]) begin
				r = (r * b) % n_w;
			end
			b = (b * b) % n_w;
		end
		return r[`RSA_W-1:0];
	endfunction

	function automatic rsa_word_t put_word(input rsa_word_t w, input int idx,
			input logic [BW-1:0] dat, input logic [BW/8-1:0] sel);
		rsa_word_t res;
		res = w;
		for (int b = 0; b < BW / 8; b++) begin
			if (sel[b]) begin
				res[idx*BW + b*8 +: 8] = dat[b*8 +: 8];
			end
		end
		return res;
	endfunction

	task automatic compare(input string name, input int idx, input logic [BW-1:0] got,
			input logic [BW-1:0] exp);
		o_checks++;
		if (got !== exp) begin
			o_errors++;
			$display("mismatch at %0t: %s[%0d] got %h expected %h",
				$time, name, idx, got, exp);
		end
	endtask

	task automatic take_write();
		int idx;
		idx = int'(i_req.adr[2:0]);
		case (i_req.adr[`RSA_ADR_W-1:3])
			3'd0: msg_m = put_word(msg_m, idx, i_req.dat, i_req.sel);
			3'd1: key_m = put_word(key_m, idx, i_req.dat, i_req.sel);
			3'd2: n_m = put_word(n_m, idx, i_req.dat, i_req.sel);
			default: begin
				// a start while a job runs is dropped by the slave
				if (i_req.adr == `RSA_A_CTRL && i_req.sel[0] && i_req.dat[0] &&
						!pending) begin
					pending     = 1'b1;
					done_m      = 1'b0;
					since_start = 0;
					ans_next    = mod_pow(msg_m, key_m, n_m);
				end
			end
		endcase
	endtask

	task automatic check_read();
		int idx;
		idx = int'(i_req.adr[2:0]);
		case (i_req.adr[`RSA_ADR_W-1:3])
			3'd0: compare("msg", idx, i_rsp.dat, msg_m[idx*BW +: BW]);
			3'd1: compare("key", idx, i_rsp.dat, key_m[idx*BW +: BW]);
			3'd2: compare("n", idx, i_rsp.dat, n_m[idx*BW +: BW]);
			3'd4: compare("ans", idx, i_rsp.dat, ans_m[idx*BW +: BW]);
			default: begin
				if (i_req.adr != `RSA_A_STAT) begin
					compare("unmapped", int'(i_req.adr), i_rsp.dat, '0);
				end else if (pending && since_start < MIN_JOB) begin
					compare("status", 0, i_rsp.dat, 32'h1);
				end else if (pending) begin
					// done must come with busy low
					if (i_rsp.dat[1]) begin
						compare("status", 0, i_rsp.dat, 32'h2);
						pending = 1'b0;
						done_m  = 1'b1;
						ans_m   = ans_next;
					end else begin
						compare("status", 0, i_rsp.dat, 32'h1);
					end
				end else begin
					compare("status", 0, i_rsp.dat, {30'b0, done_m, 1'b0});
				end
			end
		endcase
	endtask

	always @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			msg_m       = '0;
			key_m       = '0;
			n_m         = '0;
			ans_m       = '0;
			ans_next    = '0;
			pending     = 1'b0;
			done_m      = 1'b0;
			since_start = 0;
			o_errors    = 0;
			o_checks    = 0;
		end else begin
			if (pending) begin
				since_start++;
			end
			// a transfer completes on the ack cycle
			if (i_req.cyc && i_req.stb && i_rsp.ack) begin
				if (i_req.we) begin
					take_write();
				end else begin
					check_read();
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/rsa_checker.sv
`timescale 1ns/100ps
`default_nettype none

module rsa_checker
	import rsa_pkg::*;
(
	input wire i_clk,
	input wire i_rst,
	input wire wb_req_t i_req,
	input wire wb_rsp_t i_rsp,
	input wire i_start,
	input wire i_busy,
	input wire i_done
);

	int unsigned fail_cnt = 0;

	ack_single: assert property (@(posedge i_clk) disable iff (i_rst)
		i_rsp.ack |=> !i_rsp.ack)
		else begin
			$error("ack held for more than one cycle");
			fail_cnt++;
		end

	// ack only answers a live request
	ack_in_req: assert property (@(posedge i_clk) disable iff (i_rst)
		i_rsp.ack |-> (i_req.cyc && i_req.stb))
		else begin
			$error("ack without a bus request");
			fail_cnt++;
		end

	start_idle: assert property (@(posedge i_clk) disable iff (i_rst)
		i_start |-> !i_busy)
		else begin
			$error("core start while busy");
			fail_cnt++;
		end

	done_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
		i_done |=> !i_done)
		else begin
			$error("core done longer than one cycle");
			fail_cnt++;
		end

endmodule

bind rsa_top rsa_checker u_checker (
	.i_clk   (i_clk),
	.i_rst   (i_rst),
	.i_req   (i_wb),
	.i_rsp   (o_wb),
	.i_start (start),
	.i_busy  (busy),
	.i_done  (done)
);

`default_nettype wire

// File: dv/rsa_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "rsa_params.svh"

module rsa_tb
	import rsa_pkg::*;
();

	localparam int ACK_LIMIT  = 16;
	localparam int POLL_LIMIT = 200000;
	localparam int POLL_GAP   = 64;

	logic            clk;
	logic            rst;
	wb_req_t         wb_req;
	wb_rsp_t         wb_rsp;
	int unsigned     sb_errors;
	int unsigned     sb_checks;
	int unsigned     tb_errors = 0;
	longint unsigned cycles = 0;
	event            abort_ev;

	rsa_top u_rsa_top (
		.i_clk (clk),
		.i_rst (rst),
		.i_wb  (wb_req),
		.o_wb  (wb_rsp)
	);

	rsa_scoreboard u_scoreboard (
		.i_clk    (clk),
		.i_rst    (rst),
		.i_req    (wb_req),
		.i_rsp    (wb_rsp),
		.o_errors (sb_errors),
		.o_checks (sb_checks)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
	end

	task automatic close_run();
		int unsigned sva_errors;
		sva_errors = u_rsa_top.u_checker.fail_cnt;
		$display("errors: scoreboard %0d in %0d checks, assertions %0d, testbench %0d",
			sb_errors, sb_checks, sva_errors, tb_errors);
		if (sb_errors + sva_errors + tb_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	endtask

	// the main process ends the run once the stimulus stops
	task automatic abort_run(input string what);
		tb_errors++;
		$display("timeout at %0t: %s", $time, what);
		-> abort_ev;
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// one classic transfer entered and left 1 ns after a rising edge
	task automatic bus_xfer(input logic we, input logic [`RSA_ADR_W-1:0] adr,
			input logic [`RSA_BUS_W-1:0] wdat, output logic [`RSA_BUS_W-1:0] rdat);
		int n;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		wb_req.sel = '1;
		n = 0;
		@(posedge clk);
		#1;
		while (!wb_rsp.ack && n < ACK_LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!wb_rsp.ack) begin
			abort_run("no ack from the bus slave");
		end
		rdat = wb_rsp.dat;
		// slave takes write data at the end of the ack cycle
		@(posedge clk);
		#1;
		wb_req = '0;
	endtask

	task automatic wb_write(input logic [`RSA_ADR_W-1:0] adr,
			input logic [`RSA_BUS_W-1:0] dat);
		logic [`RSA_BUS_W-1:0] unused;
		bus_xfer(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [`RSA_ADR_W-1:0] adr,
			output logic [`RSA_BUS_W-1:0] dat);
		bus_xfer(1'b0, adr, '0, dat);
	endtask

	task automatic write_operand(input logic [`RSA_ADR_W-1:0] base, input rsa_word_t value);
		for (int i = 0; i < `RSA_WORDS; i++) begin
			wb_write(`RSA_ADR_W'(base + i), value[i*`RSA_BUS_W +: `RSA_BUS_W]);
		end
	endtask

	task automatic read_answer();
		logic [`RSA_BUS_W-1:0] d;
		for (int i = 0; i < `RSA_WORDS; i++) begin
			wb_read(`RSA_ADR_W'(`RSA_A_ANS + i), d);
		end
	endtask

	task automatic wait_done();
		longint unsigned t0;
		logic [`RSA_BUS_W-1:0] st;
		t0 = cycles;
		st = '0;
		while (!st[1] && cycles - t0 < POLL_LIMIT) begin
			idle(POLL_GAP);
			wb_read(`RSA_A_STAT, st);
		end
		if (!st[1]) begin
			abort_run("done bit not set within the poll limit");
		end
	endtask

	task automatic run_job(input rsa_word_t msg, input rsa_word_t key, input rsa_word_t n);
		write_operand(`RSA_A_MSG, msg);
		write_operand(`RSA_A_KEY, key);
		write_operand(`RSA_A_N, n);
		wb_write(`RSA_A_CTRL, 32'h1);
		wait_done();
		read_answer();
	endtask

	function automatic rsa_word_t rand_word();
		rsa_word_t w;
		for (int i = 0; i < `RSA_WORDS; i++) begin
			w[i*`RSA_BUS_W +: `RSA_BUS_W] = $urandom();
		end
		return w;
	endfunction

	// odd, at least 3, below 2^255
	function automatic rsa_word_t rand_modulus();
		rsa_word_t n;
		n = rand_word();
		n[`RSA_W-1] = 1'b0;
		n[0] = 1'b1;
		if (n < 3) begin
			n = 3;
		end
		return n;
	endfunction

	initial begin
		rsa_word_t             n;
		rsa_word_t             msg;
		logic [`RSA_BUS_W-1:0] d;
		void'($urandom(32'h429c30ee));
		rst    = 1'b1;
		wb_req = '0;
		fork
			begin
				repeat (2) @(posedge clk);
				#1;
				rst = 1'b0;
				idle(2);

				// state right after reset
				wb_read(`RSA_A_STAT, d);
				read_answer();

				// operand readback and unmapped words
				write_operand(`RSA_A_MSG, rand_word());
				write_operand(`RSA_A_KEY, rand_word());
				write_operand(`RSA_A_N, rand_word());
				for (int i = 0; i < 3 * `RSA_WORDS; i++) begin
					wb_read(`RSA_ADR_W'(i), d);
				end
				wb_read(`RSA_A_CTRL, d);
				wb_read(6'd26, d);
				wb_read(6'd31, d);
				wb_read(6'd40, d);
				wb_read(6'd63, d);

				for (int j = 0; j < 6; j++) begin
					n = rand_modulus();
					msg = rand_word() % n;
					run_job(msg, rand_word(), n);
				end

				// key 0, key 1, all ones
				n = rand_modulus();
				msg = rand_word() % n;
				run_job(msg, '0, n);
				run_job(msg, rsa_word_t'(1), n);
				run_job(msg, '1, n);

				// new operands and a second start while the first job runs
				n = rand_modulus();
				write_operand(`RSA_A_MSG, rand_word() % n);
				write_operand(`RSA_A_KEY, rand_word());
				write_operand(`RSA_A_N, n);
				wb_write(`RSA_A_CTRL, 32'h1);
				idle(100);
				n = rand_modulus();
				write_operand(`RSA_A_MSG, rand_word() % n);
				write_operand(`RSA_A_KEY, rand_word());
				write_operand(`RSA_A_N, n);
				wb_write(`RSA_A_CTRL, 32'h1);
				wait_done();
				read_answer();
				// a leftover start would show up as busy here
				idle(2000);
				wb_read(`RSA_A_STAT, d);

				// sticky done bit cleared by the next start
				repeat (3) begin
					idle(10);
					wb_read(`RSA_A_STAT, d);
				end
				wb_write(`RSA_A_CTRL, 32'h1);
				wb_read(`RSA_A_STAT, d);
				wait_done();
				read_answer();

				idle(4);
			end
			@(abort_ev);
		join_any
		close_run();
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
src/rsa_pkg.sv
src/rsa_prep.sv
src/rsa_mont.sv
src/rsa_core.sv
src/rsa_wb_regs.sv
src/rsa_top.sv
dv/rsa_scoreboard.sv
dv/rsa_checker.sv
dv/rsa_tb.sv
